// ==== all.f ====
arm_isa_pkg.sv
exec_types_pkg.sv
insn_classifier.sv
alu.sv
multiplier.sv
execute_stage.sv
exec_unit_top.sv
tb_clock_gen.sv
exec_unit_properties.sv
exec_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exec_unit_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status is that of grep, so a run without the pass line fails.
run: compile
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== exec_unit_tb.sv ====
`timescale 1ns/1ps

module exec_unit_tb import exec_types_pkg::*, arm_isa_pkg::*; ();

	localparam int NUM_ALU   = 160;
	localparam int NUM_MUL   = 48;
	localparam int NUM_MRS   = 8;
	localparam int NUM_MSR   = 16;
	localparam int NUM_OTHER = 24;
	localparam int NUM_TOTAL = NUM_ALU + NUM_MUL + NUM_MRS + NUM_MSR + NUM_OTHER;
	// twenty cycles per instruction covers the longest multiply with stalls.
	localparam int CYCLE_LIMIT = 4 * NUM_TOTAL * 20;

	typedef struct packed {
		logic     bubble;
		logic     wr;
		reg_num_t num;
		word_t    data;
		word_t    cpsr;
		word_t    spsr;
	} expect_t;

	logic        clk;
	logic        rst_n;
	logic        stall;
	logic        in_bubble;
	word_t       pc;
	word_t       insn;
	word_t       cpsr;
	word_t       spsr;
	word_t       op0;
	word_t       op1;
	word_t       op2;
	logic        carry;
	logic        out_stall;
	logic        out_bubble;
	word_t       out_cpsr;
	word_t       out_spsr;
	logic        write_reg;
	reg_num_t    write_num;
	word_t       write_data;
	insn_class_t cur_class;
	int          issued;
	int          retired;
	int          cycles = 0;

	tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(10)) clock_i (.clk(clk), .rst_n(rst_n));

	exec_unit_top #(.MULT_RADIX_BITS(2)) dut_i (
		.clk(clk), .rst_n(rst_n), .stall(stall), .in_bubble(in_bubble),
		.pc(pc), .insn(insn), .cpsr(cpsr), .spsr(spsr),
		.op0(op0), .op1(op1), .op2(op2), .carry(carry),
		.out_stall(out_stall), .out_bubble(out_bubble),
		.out_cpsr(out_cpsr), .out_spsr(out_spsr),
		.write_reg(write_reg), .write_num(write_num), .write_data(write_data)
	);

	task automatic check_value(string what, word_t got, word_t expected);
		if (got !== expected) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, expected);
			$display("Test failures found");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic compare_outputs(expect_t e, logic with_data);
		check_value("out_bubble", 32'(out_bubble), 32'(e.bubble));
		check_value("write_reg", 32'(write_reg), 32'(e.wr));
		check_value("out_cpsr", out_cpsr, e.cpsr);
		check_value("out_spsr", out_spsr, e.spsr);
		if (with_data) begin
			check_value("write_num", 32'(write_num), 32'(e.num));
			check_value("write_data", write_data, e.data);
		end
	endtask

	// expected stage outputs for one instruction, straight from the ISA rules.
	function automatic expect_t predict(insn_class_t cls, logic bub, word_t ins, word_t c,
			word_t s, word_t a, word_t b, word_t m, logic sh_c);
		expect_t     e;
		word_t       x;
		word_t       y;
		word_t       r;
		word_t       target;
		logic [32:0] wide;
		logic        is_sub;
		logic        use_c;
		logic        arith;
		logic        full;
		e = '{bubble: bub, wr: 1'b0, num: ins[15:12], data: '0, cpsr: c, spsr: s};
		if (bub)
			return e;
		case (cls)
		CLASS_ALU: begin
			arith = ins[24:21] inside {ALU_SUB, ALU_RSB, ALU_ADD, ALU_ADC,
				ALU_SBC, ALU_RSC, ALU_CMP, ALU_CMN};
			is_sub = !(ins[24:21] inside {ALU_ADD, ALU_ADC, ALU_CMN});
			use_c = ins[24:21] inside {ALU_ADC, ALU_SBC, ALU_RSC};
			x = (ins[24:21] inside {ALU_RSB, ALU_RSC}) ? b : a;
			y = (ins[24:21] inside {ALU_RSB, ALU_RSC}) ? a : b;
			// a borrow out of the 33-bit difference means C is clear.
			if (is_sub)
				wide = {1'b0, x} - {1'b0, y} - {32'b0, use_c & !c[CPSR_C]};
			else
				wide = {1'b0, x} + {1'b0, y} + {32'b0, use_c & c[CPSR_C]};
			case (ins[24:21])
			ALU_AND, ALU_TST: r = a & b;
			ALU_EOR, ALU_TEQ: r = a ^ b;
			ALU_ORR: r = a | b;
			ALU_MOV: r = b;
			ALU_BIC: r = a & ~b;
			ALU_MVN: r = ~b;
			default: r = wide[31:0];
			endcase
			e.wr = !(ins[24:21] inside {ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN});
			e.data = r;
			if (ins[20]) begin
				e.cpsr[CPSR_N] = r[31];
				e.cpsr[CPSR_Z] = (r == '0);
				e.cpsr[CPSR_C] = arith ? (wide[32] ^ is_sub) : sh_c;
				if (arith)
					e.cpsr[CPSR_V] = (x[31] ^ y[31] ^ !is_sub) && (r[31] != x[31]);
				if (ins[15:12] == 4'hf)
					e.cpsr = s;
			end
		end
		CLASS_MULT: begin
			r = b * m + (ins[21] ? a : '0);
			e.wr = 1'b1;
			e.num = ins[19:16];
			e.data = r;
			if (ins[20]) begin
				e.cpsr[CPSR_N] = r[31];
				e.cpsr[CPSR_Z] = (r == '0);
				e.cpsr[CPSR_C] = 1'b0;
			end
		end
		CLASS_MRS: begin
			e.wr = 1'b1;
			e.data = ins[22] ? s : c;
		end
		CLASS_MSR: begin
			full = (c[4:0] != MODE_USR) && ins[16];
			target = ins[22] ? s : c;
			for (int i = 0; i < 32; i++) begin
				if (i >= 29 || full)
					target[i] = a[i];
			end
			if (ins[22])
				e.spsr = target;
			else
				e.cpsr = target;
		end
		default: begin
		end
		endcase
		return e;
	endfunction

	function automatic word_t pick_operand();
		word_t rnd;
		rnd = $urandom();
		case (rnd[2:0])
		3'd0: return '0;
		3'd1: return 32'd1;
		3'd2: return '1;
		3'd3: return {24'h0, rnd[15:8]};
		default: return $urandom();
		endcase
	endfunction

	task automatic load_state();
		word_t rnd;
		rnd = $urandom();
		pc = $urandom();
		cpsr = $urandom();
		spsr = $urandom();
		op0 = $urandom();
		op1 = $urandom();
		op2 = $urandom();
		carry = rnd[0];
		in_bubble = 1'b0;
	endtask

	// holds the current instruction until the stage takes it, with random
	// downstream stall pulses along the way.
	task automatic issue();
		word_t rnd;
		logic  taken;
		taken = 1'b0;
		while (!taken) begin
			rnd = $urandom();
			stall = (rnd[2:0] == 3'd0);
			@(negedge clk);
			taken = !out_stall;
			@(posedge clk);
			#2;
		end
		// only a slot that carries work comes out as a result.
		if (!in_bubble)
			issued++;
	endtask

	initial begin : stimulus
		word_t      rnd;
		logic [3:0] opc;
		void'($urandom(77515));
		stall = 1'b0;
		in_bubble = 1'b1;
		pc = '0;
		insn = '0;
		cpsr = '0;
		spsr = '0;
		op0 = '0;
		op1 = '0;
		op2 = '0;
		carry = 1'b0;
		cur_class = CLASS_OTHER;
		issued = 0;
		@(negedge rst_n);
		@(posedge rst_n);
		@(posedge clk);
		#2;
		for (int i = 0; i < NUM_ALU; i++) begin
			load_state();
			rnd = $urandom();
			opc = i[3:0];
			cur_class = CLASS_ALU;
			// compares always set S, and r15 turns up more often than chance.
			insn = {4'he, 3'b001, opc, rnd[4] | (opc[3:2] == 2'b10), rnd[12:9],
				(rnd[27:25] == 3'd0) ? 4'hf : rnd[8:5], rnd[24:13]};
			issue();
		end
		for (int i = 0; i < NUM_MUL; i++) begin
			load_state();
			rnd = $urandom();
			op0 = pick_operand();
			op1 = pick_operand();
			op2 = pick_operand();
			cur_class = CLASS_MULT;
			insn = {4'he, 6'b000000, rnd[0], rnd[1], rnd[5:2], rnd[9:6], rnd[13:10],
				4'b1001, rnd[17:14]};
			issue();
		end
		for (int i = 0; i < NUM_MRS; i++) begin
			load_state();
			rnd = $urandom();
			cur_class = CLASS_MRS;
			insn = {4'he, 5'b00010, i[0], 2'b00, 4'hf, rnd[3:0], 12'h000};
			issue();
		end
		for (int i = 0; i < NUM_MSR; i++) begin
			load_state();
			rnd = $urandom();
			cpsr[4:0] = i[2] ? MODE_USR : MODE_SVC;
			cur_class = CLASS_MSR;
			insn = {4'he, 5'b00010, i[0], 2'b10, 3'b100, i[1], 4'hf, 8'h00, rnd[3:0]};
			issue();
		end
		for (int i = 0; i < NUM_OTHER; i++) begin
			load_state();
			rnd = $urandom();
			cur_class = CLASS_OTHER;
			case (rnd[31:30])
			2'd0: insn = {4'he, 3'b010, rnd[24:0]};
			2'd1: insn = {4'he, 3'b101, rnd[24:0]};
			2'd2: insn = {4'he, 4'hf, rnd[23:0]};
			default: insn = {4'he, 8'b00010000, rnd[7:0], 4'h0, 4'b1001, rnd[11:8]};
			endcase
			// a bubble may carry any encoding at all.
			in_bubble = i[0];
			if (in_bubble)
				insn = rnd;
			issue();
		end
		in_bubble = 1'b1;
		stall = 1'b0;
		repeat (2) @(posedge clk);
		check_value("retired instruction count", 32'(retired), 32'(issued));
		$display("All tests passed!");
		$finish;
	end

	// inputs are sampled on the falling edge and outputs checked just after
	// the following rising edge.
	initial begin : compare
		expect_t expected;
		expect_t snap;
		logic    accept;
		logic    held;
		logic    running;
		logic    loaded;
		retired = 0;
		forever begin
			@(negedge clk);
			accept = rst_n && !out_stall;
			held = rst_n && stall;
			running = rst_n && out_stall && !stall;
			loaded = rst_n && !stall;
			// outside a running multiply, out_stall is just the downstream stall.
			if (stall || in_bubble || cur_class != CLASS_MULT)
				check_value("out_stall", 32'(out_stall), 32'(stall));
			expected = predict(cur_class, in_bubble, insn, cpsr, spsr, op0, op1, op2, carry);
			snap = {out_bubble, write_reg, write_num, write_data, out_cpsr, out_spsr};
			@(posedge clk);
			#1;
			if (loaded && !out_bubble)
				retired++;
			if (accept) begin
				compare_outputs(expected, expected.wr);
			end else if (held) begin
				compare_outputs(snap, 1'b1);
			end else if (running) begin
				check_value("out_bubble during multiply", 32'(out_bubble), 32'd1);
				check_value("write_reg during multiply", 32'(write_reg), 32'd0);
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test failures found");
			$fatal(1, "cycle limit reached");
		end
	end

endmodule

// ==== exec_unit_properties.sv ====
`timescale 1ns/1ps

module exec_unit_properties import exec_types_pkg::*; #(
	parameter int MULT_RADIX_BITS = 2
) (
	input logic     clk,
	input logic     rst_n,
	input logic     stall,
	input logic     out_stall,
	input logic     out_bubble,
	input logic     write_reg,
	input logic     mult_start,
	input word_t    out_cpsr,
	input word_t    out_spsr,
	input reg_num_t write_num,
	input word_t    write_data
);

	localparam int LAT_MAX = 32 / MULT_RADIX_BITS + 2;

	// cycles since the multiplier was started, zero once out_stall has
	// fallen. cycles with downstream stall high are not counted, since
	// they can hold a finished product back.
	int unsigned mult_wait;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			mult_wait <= 0;
		else if (mult_start)
			mult_wait <= 1;
		else if (!out_stall)
			mult_wait <= 0;
		else if (mult_wait != 0 && !stall)
			mult_wait <= mult_wait + 1;
	end

	reset_bubble: assert property (@(posedge clk) !rst_n |-> out_bubble)
		else $error("out_bubble is low during reset");

	bubble_no_write: assert property (@(posedge clk) disable iff (!rst_n)
		out_bubble |-> !write_reg)
		else $error("write_reg is set for a bubble");

	stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(out_bubble) && $stable(write_reg) && $stable(out_cpsr)
			&& $stable(out_spsr) && $stable(write_num) && $stable(write_data))
		else $error("outputs changed while stall was high");

	mult_latency: assert property (@(posedge clk) disable iff (!rst_n)
		mult_wait <= LAT_MAX)
		else $error("out_stall did not fall within the multiply latency bound");

endmodule

bind execute_stage exec_unit_properties #(.MULT_RADIX_BITS(MULT_RADIX_BITS)) props_i (
	.clk(clk), .rst_n(rst_n), .stall(stall), .out_stall(out_stall),
	.out_bubble(out_bubble), .write_reg(write_reg),
	.mult_start(mult_start),
	.out_cpsr(out_cpsr), .out_spsr(out_spsr),
	.write_num(write_num), .write_data(write_data)
);

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// reset falls just after time zero so the flops see a clean edge, and
	// rises a little after the last reset clock edge.
	initial begin
		rst_n = 1'b1;
		#1 rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 rst_n = 1'b1;
	end

endmodule

// ==== exec_unit_top.sv ====
`timescale 1ns/1ps

module exec_unit_top import exec_types_pkg::*; #(
	parameter int MULT_RADIX_BITS = 2
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     stall,
	input  logic     in_bubble,
	input  word_t    pc,
	input  word_t    insn,
	input  word_t    cpsr,
	input  word_t    spsr,
	input  word_t    op0,
	input  word_t    op1,
	input  word_t    op2,
	input  logic     carry,
	output logic     out_stall,
	output logic     out_bubble,
	output word_t    out_cpsr,
	output word_t    out_spsr,
	output logic     write_reg,
	output reg_num_t write_num,
	output word_t    write_data
);

	// the radix trades multiplier area against multiply latency.
	execute_stage #(.MULT_RADIX_BITS(MULT_RADIX_BITS)) exec_i (
		.clk(clk), .rst_n(rst_n),
		.stall(stall), .in_bubble(in_bubble),
		.pc(pc), .insn(insn), .cpsr(cpsr), .spsr(spsr),
		.op0(op0), .op1(op1), .op2(op2), .carry(carry),
		.out_stall(out_stall), .out_bubble(out_bubble),
		.out_cpsr(out_cpsr), .out_spsr(out_spsr),
		.write_reg(write_reg), .write_num(write_num), .write_data(write_data)
	);

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import exec_types_pkg::*, arm_isa_pkg::*; #(
	parameter int MULT_RADIX_BITS = 2
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     stall,
	input  logic     in_bubble,
	input  word_t    pc,
	input  word_t    insn,
	input  word_t    cpsr,
	input  word_t    spsr,
	input  word_t    op0,
	input  word_t    op1,
	input  word_t    op2,
	input  logic     carry,
	output logic     out_stall,
	output logic     out_bubble,
	output word_t    out_cpsr,
	output word_t    out_spsr,
	output logic     write_reg,
	output reg_num_t write_num,
	output word_t    write_data
);

	insn_class_t insn_class;
	word_t       alu_result;
	word_t       alu_cpsr_out;
	logic        alu_setres;
	logic        mult_start;
	logic        mult_done;
	word_t       mult_result;
	logic        mult_active;
	logic        mult_fin;
	logic        busy;
	logic        mult_ready;
	word_t       msr_mask;
	logic        next_bubble;
	word_t       next_cpsr;
	word_t       next_spsr;
	logic        next_write;
	reg_num_t    next_num;
	word_t       next_data;

	insn_classifier classifier_i (.insn(insn), .insn_class(insn_class));

	alu alu_i (
		.in0(op0), .in1(op1), .cpsr(cpsr), .op(insn[24:21]),
		.setflags(insn[20]), .shifter_carry(carry),
		.result(alu_result), .cpsr_out(alu_cpsr_out), .setres(alu_setres)
	);

	// op0 is Rn (the accumulator for MLA), op1 is Rm and op2 is Rs.
	multiplier #(.MULT_RADIX_BITS(MULT_RADIX_BITS)) mult_i (
		.clk(clk), .rst_n(rst_n), .start(mult_start),
		.acc0(insn[21] ? op0 : '0), .in0(op1), .in1(op2),
		.done(mult_done), .result(mult_result)
	);

	// pc is part of the stage boundary but no instruction handled here
	// needs it, since r15 operands arrive already read.
	assign mult_active = (insn_class == CLASS_MULT) && !in_bubble;
	assign mult_fin = mult_done | mult_ready;
	assign mult_start = mult_active && !busy && !mult_ready;
	assign out_stall = stall | (mult_active & ~mult_fin);

	// busy covers the run of one multiply. mult_ready remembers a product
	// that finished while downstream was stalled, until it is taken.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			mult_ready <= 1'b0;
		end else begin
			if (mult_start)
				busy <= 1'b1;
			else if (mult_done)
				busy <= 1'b0;
			if (mult_done && stall)
				mult_ready <= 1'b1;
			else if (!stall)
				mult_ready <= 1'b0;
		end
	end

	// user mode, or a clear bit 16, limits MSR to the top three flags.
	assign msr_mask = (cpsr[4:0] == MODE_USR || !insn[16]) ? 32'he000_0000 : 32'hffff_ffff;

	always_comb begin
		next_bubble = in_bubble;
		next_cpsr = cpsr;
		next_spsr = spsr;
		next_write = 1'b0;
		next_num = insn[15:12];
		next_data = alu_result;
		case (insn_class)
		CLASS_MULT: begin
			next_bubble = in_bubble | ~mult_fin;
			next_write = 1'b1;
			next_num = insn[19:16];
			next_data = mult_result;
			if (insn[20]) begin
				next_cpsr[CPSR_N] = mult_result[31];
				next_cpsr[CPSR_Z] = (mult_result == '0);
				next_cpsr[CPSR_C] = 1'b0;
			end
		end
		CLASS_MRS: begin
			next_write = 1'b1;
			next_data = insn[22] ? spsr : cpsr;
		end
		CLASS_MSR: begin
			if (insn[22])
				next_spsr = (op0 & msr_mask) | (spsr & ~msr_mask);
			else
				next_cpsr = (op0 & msr_mask) | (cpsr & ~msr_mask);
		end
		CLASS_ALU: begin
			next_write = alu_setres;
			// a flag-setting write to the pc returns from an exception.
			next_cpsr = (insn[15:12] == 4'hf && insn[20]) ? spsr : alu_cpsr_out;
		end
		default: begin
		end
		endcase
		// an empty slot carries no writeback and leaves the PSRs alone.
		if (next_bubble) begin
			next_write = 1'b0;
			next_cpsr = cpsr;
			next_spsr = spsr;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_bubble <= 1'b1;
			write_reg <= 1'b0;
			out_cpsr <= '0;
			out_spsr <= '0;
		end else if (!stall) begin
			out_bubble <= next_bubble;
			write_reg <= next_write;
			out_cpsr <= next_cpsr;
			out_spsr <= next_spsr;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			write_num <= next_num;
			write_data <= next_data;
		end
	end

endmodule

// ==== multiplier.sv ====
`timescale 1ns/1ps

module multiplier import exec_types_pkg::*; #(
	parameter int MULT_RADIX_BITS = 2
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  start,
	input  word_t acc0,
	input  word_t in0,
	input  word_t in1,
	output logic  done,
	output word_t result
);

	if (MULT_RADIX_BITS != 1 && MULT_RADIX_BITS != 2 && MULT_RADIX_BITS != 4) begin : g_bad_radix
		$error("MULT_RADIX_BITS must be 1, 2 or 4");
	end

	mult_state_t state;
	word_t       mcand;
	word_t       mplier;
	word_t       acc;
	word_t       partial;

	// multiplicand times the low MULT_RADIX_BITS bits of the multiplier.
	always_comb begin
		partial = '0;
		for (int i = 0; i < MULT_RADIX_BITS; i++) begin
			if (mplier[i])
				partial = partial + (mcand << i);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= MULT_IDLE;
		end else if (start) begin
			state <= MULT_RUN;
		end else if (state == MULT_RUN && mplier == '0) begin
			state <= MULT_DONE;
		end else if (state == MULT_DONE) begin
			state <= MULT_IDLE;
		end
	end

	// in1 is the multiplier, so small values of it finish early.
	always_ff @(posedge clk) begin
		if (start) begin
			mcand <= in0;
			mplier <= in1;
			acc <= acc0;
		end else if (state == MULT_RUN && mplier != '0) begin
			acc <= acc + partial;
			mcand <= mcand << MULT_RADIX_BITS;
			mplier <= mplier >> MULT_RADIX_BITS;
		end
	end

	// acc stays put after the run, so the product remains readable until
	// the next start.
	assign done = (state == MULT_DONE);
	assign result = acc;

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu import exec_types_pkg::*, arm_isa_pkg::*; (
	input  word_t   in0,
	input  word_t   in1,
	input  word_t   cpsr,
	input  alu_op_t op,
	input  logic    setflags,
	input  logic    shifter_carry,
	output word_t   result,
	output word_t   cpsr_out,
	output logic    setres
);

	word_t       add_a;
	word_t       add_b;
	logic        add_cin;
	logic [32:0] sum;
	logic        sum_v;
	logic        arith;
	logic        flag_c;
	logic        flag_v;

	// all arithmetic shares one adder. subtraction is a + ~b + 1, so the
	// carry out is the ARM "not borrow" without further correction.
	always_comb begin
		add_a = in0;
		add_b = ~in1;
		add_cin = 1'b1;
		case (op)
		ALU_RSB, ALU_RSC: begin
			add_a = in1;
			add_b = ~in0;
		end
		ALU_ADD, ALU_ADC, ALU_CMN: begin
			add_b = in1;
			add_cin = 1'b0;
		end
		default: begin
		end
		endcase
		// the with-carry forms take the old C in place of the constant.
		if (op == ALU_ADC || op == ALU_SBC || op == ALU_RSC)
			add_cin = cpsr[CPSR_C];
	end

	assign sum = {1'b0, add_a} + {1'b0, add_b} + {32'b0, add_cin};
	assign sum_v = (add_a[31] == add_b[31]) && (sum[31] != add_a[31]);

	always_comb begin
		arith = 1'b0;
		case (op)
		ALU_AND, ALU_TST: result = in0 & in1;
		ALU_EOR, ALU_TEQ: result = in0 ^ in1;
		ALU_ORR:          result = in0 | in1;
		ALU_MOV:          result = in1;
		ALU_BIC:          result = in0 & ~in1;
		ALU_MVN:          result = ~in1;
		default: begin
			result = sum[31:0];
			arith = 1'b1;
		end
		endcase
	end

	// logical operations keep V and take C from the shifter.
	assign flag_c = arith ? sum[32] : shifter_carry;
	assign flag_v = arith ? sum_v : cpsr[CPSR_V];

	always_comb begin
		cpsr_out = cpsr;
		if (setflags) begin
			cpsr_out[CPSR_N] = result[31];
			cpsr_out[CPSR_Z] = (result == '0);
			cpsr_out[CPSR_C] = flag_c;
			cpsr_out[CPSR_V] = flag_v;
		end
	end

	// the test and compare opcodes only touch the flags.
	assign setres = !(op inside {ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN});

endmodule

// ==== insn_classifier.sv ====
`timescale 1ns/1ps

module insn_classifier import exec_types_pkg::*, arm_isa_pkg::*; (
	input  word_t       insn,
	output insn_class_t insn_class
);

	// the condition field (bits 31 to 28) is ignored here, since condition
	// evaluation happens before this stage.
	// order matters. multiply, swap and the halfword transfers all live
	// inside the data-processing space, so they are matched first.
	always_comb begin
		casez (insn)
		// MUL and MLA.
		32'b????_0000_00??_????_????_????_1001_????:
			insn_class = CLASS_MULT;
		// long multiplies are not handled by this stage.
		32'b????_0000_1???_????_????_????_1001_????:
			insn_class = CLASS_OTHER;
		// SWP and SWPB.
		32'b????_0001_0?00_????_????_0000_1001_????:
			insn_class = CLASS_OTHER;
		// MRS from CPSR or SPSR.
		32'b????_0001_0?00_1111_????_0000_0000_0000:
			insn_class = CLASS_MRS;
		// MSR, register source, full or flags only.
		32'b????_0001_0?10_100?_1111_0000_0000_????:
			insn_class = CLASS_MSR;
		// MSR, immediate source.
		32'b????_0011_0?10_100?_1111_????_????_????:
			insn_class = CLASS_MSR;
		// BX.
		32'b????_0001_0010_1111_1111_1111_0001_????:
			insn_class = CLASS_OTHER;
		// halfword and signed transfers, register offset.
		32'b????_000?_?0??_????_????_0000_1??1_????:
			insn_class = CLASS_OTHER;
		// halfword and signed transfers, immediate offset.
		32'b????_000?_?1??_????_????_????_1??1_????:
			insn_class = CLASS_OTHER;
		// compare opcodes without S are not data processing.
		32'b????_00?1_0??0_????_????_????_????_????:
			insn_class = CLASS_OTHER;
		// what is left of the 00 space is plain data processing.
		32'b????_00??_????_????_????_????_????_????:
			insn_class = CLASS_ALU;
		// loads, stores, branches, coprocessor and SWI.
		default:
			insn_class = CLASS_OTHER;
		endcase
	end

endmodule

// ==== exec_types_pkg.sv ====
package exec_types_pkg;

	// one machine word, used for operands, results and the PSRs.
	typedef logic [31:0] word_t;

	// register number r0 to r15.
	typedef logic [3:0] reg_num_t;

	// data-processing opcode field.
	typedef logic [3:0] alu_op_t;

	// the multiplier sits in idle until started, then runs until the
	// remaining multiplier bits are all zero and spends one cycle in done.
	typedef enum logic [1:0] {
		MULT_IDLE = 2'b00,
		MULT_RUN  = 2'b01,
		MULT_DONE = 2'b10
	} mult_state_t;

endpackage

// ==== arm_isa_pkg.sv ====
package arm_isa_pkg;

	// instruction classes that the execute stage tells apart.
	typedef logic [3:0] insn_class_t;

	localparam insn_class_t CLASS_OTHER = 4'h0;
	localparam insn_class_t CLASS_ALU   = 4'h1;
	localparam insn_class_t CLASS_MULT  = 4'h2;
	localparam insn_class_t CLASS_MRS   = 4'h3;
	localparam insn_class_t CLASS_MSR   = 4'h4;

	// data-processing opcodes as found in instruction bits 24 to 21.
	localparam logic [3:0] ALU_AND = 4'h0;
	localparam logic [3:0] ALU_EOR = 4'h1;
	localparam logic [3:0] ALU_SUB = 4'h2;
	localparam logic [3:0] ALU_RSB = 4'h3;
	localparam logic [3:0] ALU_ADD = 4'h4;
	localparam logic [3:0] ALU_ADC = 4'h5;
	localparam logic [3:0] ALU_SBC = 4'h6;
	localparam logic [3:0] ALU_RSC = 4'h7;
	localparam logic [3:0] ALU_TST = 4'h8;
	localparam logic [3:0] ALU_TEQ = 4'h9;
	localparam logic [3:0] ALU_CMP = 4'ha;
	localparam logic [3:0] ALU_CMN = 4'hb;
	localparam logic [3:0] ALU_ORR = 4'hc;
	localparam logic [3:0] ALU_MOV = 4'hd;
	localparam logic [3:0] ALU_BIC = 4'he;
	localparam logic [3:0] ALU_MVN = 4'hf;

	// condition flag positions in the CPSR and SPSR.
	localparam int CPSR_N = 31;
	localparam int CPSR_Z = 30;
	localparam int CPSR_C = 29;
	localparam int CPSR_V = 28;

	// processor mode field, PSR bits 4 to 0.
	localparam logic [4:0] MODE_USR = 5'b10000;
	localparam logic [4:0] MODE_FIQ = 5'b10001;
	localparam logic [4:0] MODE_IRQ = 5'b10010;
	localparam logic [4:0] MODE_SVC = 5'b10011;
	localparam logic [4:0] MODE_ABT = 5'b10111;
	localparam logic [4:0] MODE_UND = 5'b11011;
	localparam logic [4:0] MODE_SYS = 5'b11111;

endpackage
